/* compile.f */
hdl/cache_geom_pkg.sv
hdl/mem_msg_pkg.sv
hdl/cache_req_decode.sv
hdl/cache_line_state.sv
hdl/cache_ctrl_fsm.sv
hdl/way_enable_gen.sv
hdl/cache_ctrl_top.sv
tests/cache_ctrl_tb.sv

/* hdl/cache_ctrl_fsm.sv */
/* blocking control FSM of the cache, one request in flight
   sequences tag check, eviction, refill and the response, and counts */
`default_nettype none

module cache_ctrl_fsm (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  cachereq_val,
  output logic                                  cachereq_rdy,
  output logic                                  cacheresp_val,
  input  logic                                  cacheresp_rdy,
  output logic                                  memreq_val,
  input  logic                                  memreq_rdy,
  output logic                                  memreq_type,
  input  logic                                  memresp_val,
  output logic                                  memresp_rdy,
  input  logic [mem_msg_pkg::req_type_bits-1:0] req_type,
  input  logic                                  hit,
  input  logic                                  hit_way,
  input  logic                                  victim_way,
  input  logic                                  victim_dirty,
  input  logic                                  is_write_init,
  output logic                                  fill_strobe,
  output logic                                  write_strobe,
  output logic                                  evict_strobe,
  output logic                                  touch_strobe,
  output logic                                  target_way,
  output logic                                  tag_wr,
  output logic                                  data_wr,
  output logic                                  refill,
  output logic                                  cachereq_en,
  output logic                                  memresp_en,
  output logic                                  tag_array_ren,
  output logic                                  data_array_ren,
  output logic                                  read_data_reg_en,
  output logic                                  read_tag_reg_en,
  output logic [cache_geom_pkg::count_bits-1:0] req_count,
  output logic [cache_geom_pkg::count_bits-1:0] miss_count
);

  import cache_geom_pkg::*;
  import mem_msg_pkg::*;

  typedef enum logic [3:0] {
    idle, tag_check, write_init, evict_req, evict_wait,
    refill_req, refill_wait, access, respond
  } state_t;

  state_t state;
  state_t next_state;

  // --------------------------------------------------------------------------
  // state register and next state
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      idle:        if (cachereq_val) next_state = tag_check;
      tag_check: begin
        if (is_write_init)     next_state = write_init;
        else if (hit)          next_state = access;
        else if (victim_dirty) next_state = evict_req;
        else                   next_state = refill_req;
      end
      write_init:  next_state = respond;
      evict_req:   if (memreq_rdy) next_state = evict_wait;
      evict_wait:  if (memresp_val) next_state = refill_req;
      refill_req:  if (memreq_rdy) next_state = refill_wait;
      refill_wait: if (memresp_val) next_state = access;
      access:      next_state = respond;
      respond:     if (cacheresp_rdy) next_state = idle;
      default:     next_state = idle;
    endcase
  end

  // --------------------------------------------------------------------------
  // outputs, decoded from the state
  // --------------------------------------------------------------------------
  // after a refill the new line hits, on the same way as the victim
  assign target_way = hit ? hit_way : victim_way;

  assign cachereq_rdy  = (state == idle);
  assign cachereq_en   = (state == idle) && cachereq_val;
  assign cacheresp_val = (state == respond);
  assign memreq_val    = (state == evict_req) || (state == refill_req);
  assign memreq_type   = (state == evict_req) ? memreq_write : memreq_read;
  assign memresp_rdy   = (state == evict_wait) || (state == refill_wait);
  assign memresp_en    = (state == refill_wait) && memresp_val;
  assign refill        = (state == refill_wait);

  // victim tag and data go to the write-back registers
  assign tag_array_ren   = (state == tag_check) || (state == evict_req);
  assign read_tag_reg_en = (state == evict_req);
  assign data_array_ren  = (state == evict_req) ||
                           ((state == access) && (req_type == req_read));
  assign read_data_reg_en = data_array_ren;

  // array writes: refill line, write-init word, store word
  assign tag_wr  = (state == write_init) || memresp_en;
  assign data_wr = tag_wr || ((state == access) && (req_type == req_write));

  assign fill_strobe  = tag_wr;
  assign evict_strobe = (state == evict_wait) && memresp_val;
  assign write_strobe = (state == access) && (req_type == req_write);
  assign touch_strobe = (state == access) || (state == write_init);

  // --------------------------------------------------------------------------
  // statistics
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      req_count  <= '0;
      miss_count <= '0;
    end else begin
      if (cachereq_val && cachereq_rdy) begin
        req_count <= req_count + 1'b1;
      end
      if ((state == tag_check) && !is_write_init && !hit) begin
        miss_count <= miss_count + 1'b1;
      end
    end
  end

  // a memory request and its type hold until memreq_rdy
  assert property (@(posedge clk) disable iff (reset)
    (memreq_val && !memreq_rdy) |=> (memreq_val && $stable(memreq_type)))
    else $error("memreq_val dropped or memreq_type changed before memreq_rdy");

endmodule

`default_nettype wire

/* hdl/cache_ctrl_top.sv */
/* controller of the blocking write-back data cache
   the datapath with request register and arrays sits outside */
`default_nettype none

module cache_ctrl_top (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  cachereq_val,
  output logic                                  cachereq_rdy,
  input  logic [mem_msg_pkg::req_type_bits-1:0] req_type,
  input  logic [cache_geom_pkg::addr_bits-1:0]  req_addr,
  input  logic [cache_geom_pkg::num_ways-1:0]   tag_match,
  output logic                                  cacheresp_val,
  input  logic                                  cacheresp_rdy,
  output logic                                  memreq_val,
  input  logic                                  memreq_rdy,
  output logic                                  memreq_type,
  input  logic                                  memresp_val,
  output logic                                  memresp_rdy,
  output logic                                  cachereq_en,
  output logic                                  memresp_en,
  output logic                                  is_refill,
  output logic                                  tag_array_ren,
  output logic                                  data_array_ren,
  output logic                                  read_data_reg_en,
  output logic                                  read_tag_reg_en,
  output logic [cache_geom_pkg::num_ways-1:0]   tag_array_wen,
  output logic [cache_geom_pkg::num_ways-1:0]   data_array_wen,
  output logic [cache_geom_pkg::line_bytes-1:0] data_array_wben0,
  output logic [cache_geom_pkg::line_bytes-1:0] data_array_wben1,
  output logic [cache_geom_pkg::word_sel_bits-1:0] read_byte_sel,
  output logic                                  access_way,
  output logic [cache_geom_pkg::count_bits-1:0] req_count,
  output logic [cache_geom_pkg::count_bits-1:0] miss_count
);

  import cache_geom_pkg::*;

  logic [index_bits-1:0] index;
  logic [num_ways-1:0]   set_valid;
  logic [num_ways-1:0]   set_dirty;
  logic                  set_lru_way;
  logic                  hit;
  logic                  hit_way;
  logic                  victim_way;
  logic                  victim_dirty;
  logic                  is_write_init;
  logic                  fill_strobe;
  logic                  write_strobe;
  logic                  evict_strobe;
  logic                  touch_strobe;
  logic                  tag_wr;
  logic                  data_wr;

  // address fields of the held request
  assign index         = req_addr[index_lsb +: index_bits];
  assign read_byte_sel = req_addr[index_lsb-1 -: word_sel_bits];

  cache_req_decode u_decode (.*);

  cache_line_state u_line_state (.*, .target_way(access_way));

  cache_ctrl_fsm u_fsm (.*, .target_way(access_way), .refill(is_refill));

  way_enable_gen u_way_en (
    .*,
    .target_way (access_way),
    .refill     (is_refill),
    .word_sel   (read_byte_sel)
  );

endmodule

`default_nettype wire

/* hdl/cache_geom_pkg.sv */
/* geometry of the 2-way, 8-set data cache with 16-byte lines
   imported by every controller module */
`default_nettype none

package cache_geom_pkg;

  // --------------------------------------------------------------------------
  // sets and ways
  // --------------------------------------------------------------------------
  localparam int num_sets   = 8;
  localparam int num_ways   = 2;
  localparam int index_bits = 3;

  // --------------------------------------------------------------------------
  // address layout
  // --------------------------------------------------------------------------
  localparam int line_bytes = 16;
  localparam int addr_bits  = 32;

  // word within the line sits just below the index, bits 3:2
  localparam int word_sel_bits = 2;
  localparam int index_lsb     = 4;

  // statistics counters, wrap around
  localparam int count_bits = 10;

  localparam logic [line_bytes-1:0] full_line_ben = '1;

endpackage

`default_nettype wire

/* hdl/cache_line_state.sv */
/* valid, dirty and LRU bits for every line of the cache
   strobes from the control FSM update the indexed set on the next edge */
`default_nettype none

module cache_line_state (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [cache_geom_pkg::index_bits-1:0] index,
  input  logic                                  fill_strobe,
  input  logic                                  write_strobe,
  input  logic                                  evict_strobe,
  input  logic                                  touch_strobe,
  input  logic                                  target_way,
  output logic [cache_geom_pkg::num_ways-1:0]   set_valid,
  output logic [cache_geom_pkg::num_ways-1:0]   set_dirty,
  output logic                                  set_lru_way
);

  import cache_geom_pkg::*;

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------
  logic [num_sets-1:0][num_ways-1:0] valid_bits;
  logic [num_sets-1:0][num_ways-1:0] dirty_bits;

  // way used most recently, per set
  logic [num_sets-1:0] lru_way;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      lru_way    <= '0;
    end else begin
      // refilled line is valid and clean
      if (fill_strobe) begin
        valid_bits[index][target_way] <= 1'b1;
        dirty_bits[index][target_way] <= 1'b0;
      end
      // victim written back
      if (evict_strobe) begin
        dirty_bits[index][target_way] <= 1'b0;
      end
      // store hit, or store after refill
      if (write_strobe) begin
        dirty_bits[index][target_way] <= 1'b1;
      end
      if (touch_strobe) begin
        lru_way[index] <= target_way;
      end
    end
  end

  // --------------------------------------------------------------------------
  // reads of the indexed set
  // --------------------------------------------------------------------------
  assign set_valid   = valid_bits[index];
  assign set_dirty   = dirty_bits[index];
  assign set_lru_way = lru_way[index];

  // the FSM only marks a line dirty after it was filled
  assert property (@(posedge clk) disable iff (reset)
    (set_dirty & ~set_valid) == '0)
    else $error("dirty bit on invalid line, set %0d valid %b dirty %b",
                index, set_valid, set_dirty);

endmodule

`default_nettype wire

/* hdl/cache_req_decode.sv */
/* classifies the request held in the datapath register
   hit and hit way from valid and tag_match, victim from the LRU bit */
`default_nettype none

module cache_req_decode (
  input  logic [mem_msg_pkg::req_type_bits-1:0] req_type,
  input  logic [cache_geom_pkg::addr_bits-1:0]  req_addr,
  input  logic [cache_geom_pkg::num_ways-1:0]   tag_match,
  input  logic [cache_geom_pkg::num_ways-1:0]   set_valid,
  input  logic [cache_geom_pkg::num_ways-1:0]   set_dirty,
  input  logic                                  set_lru_way,
  output logic                                  hit,
  output logic                                  hit_way,
  output logic                                  victim_way,
  output logic                                  victim_dirty,
  output logic                                  is_write_init
);

  import cache_geom_pkg::*;
  import mem_msg_pkg::*;

  logic [num_ways-1:0] hit_vec;

  // a stale tag on an invalid way never counts
  assign hit_vec = set_valid & tag_match;
  assign hit     = |hit_vec;
  assign hit_way = hit_vec[1];

  // replace the way that was not used last
  assign victim_way   = ~set_lru_way;
  assign victim_dirty = set_valid[victim_way] & set_dirty[victim_way];

  assign is_write_init = (req_type == req_write_init);

  // tag array and line state must agree: one copy of a line per set,
  // and requests are word aligned
  always_comb begin
    if (!$isunknown({hit_vec, req_addr[1:0]})) begin
      assert ($onehot0(hit_vec))
        else $error("line present in both ways of set, hit_vec %b", hit_vec);
      assert (req_addr[1:0] == 2'b00)
        else $error("unaligned request address %h", req_addr);
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_msg_pkg.sv */
/* type codes of cache requests and of memory requests
   shared by the decode, the control FSM and the top level */
`default_nettype none

package mem_msg_pkg;

  // cache request types
  localparam int req_type_bits = 2;

  localparam logic [req_type_bits-1:0] req_read       = 2'd0;
  localparam logic [req_type_bits-1:0] req_write      = 2'd1;
  localparam logic [req_type_bits-1:0] req_write_init = 2'd2;

  // memory request type, one bit
  localparam logic memreq_read  = 1'b0;
  localparam logic memreq_write = 1'b1;

endpackage

`default_nettype wire

/* hdl/way_enable_gen.sv */
/* per-way tag and data write enables with byte enables
   a refill writes the whole line, a store writes one 4-byte word */
`default_nettype none

module way_enable_gen (
  input  logic                                     tag_wr,
  input  logic                                     data_wr,
  input  logic                                     refill,
  input  logic                                     target_way,
  input  logic [cache_geom_pkg::word_sel_bits-1:0] word_sel,
  output logic [cache_geom_pkg::num_ways-1:0]      tag_array_wen,
  output logic [cache_geom_pkg::num_ways-1:0]      data_array_wen,
  output logic [cache_geom_pkg::line_bytes-1:0]    data_array_wben0,
  output logic [cache_geom_pkg::line_bytes-1:0]    data_array_wben1
);

  import cache_geom_pkg::*;

  localparam logic [line_bytes-1:0] word_ben = 16'h000f;

  logic [num_ways-1:0]   way_sel;
  logic [line_bytes-1:0] ben;

  assign way_sel = num_ways'(1) << target_way;

  // word group at address bits 3:2
  assign ben = refill ? full_line_ben : (word_ben << {word_sel, 2'b00});

  assign tag_array_wen  = tag_wr  ? way_sel : '0;
  assign data_array_wen = data_wr ? way_sel : '0;

  assign data_array_wben0 = data_array_wen[0] ? ben : '0;
  assign data_array_wben1 = data_array_wen[1] ? ben : '0;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the cache controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_ctrl_tb \
  -f compile.f -o vsim && \
  ./obj_dir/vsim | grep -F "=== PASS ===" || \
  { echo "simulation failed"; exit 1; }

/* tests/cache_ctrl_tb.sv */
/* testbench of the cache controller with a model datapath and memory
   concurrent assertions compare against a reference model of line state */
`default_nettype none

module cache_ctrl_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_directed = 9;
  localparam int n_random   = 60;
  localparam int n_reqs     = n_directed + n_random;
  localparam int cycle_limit = 40 * n_reqs;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        cachereq_val = 1'b0;
  logic        cacheresp_rdy = 1'b0;
  logic        memreq_rdy = 1'b0;
  logic        memresp_val = 1'b0;
  logic [1:0]  req_type = '0;
  logic [31:0] req_addr = '0;
  logic [1:0]  tag_match;
  logic [1:0]  nxt_type = '0;
  logic [31:0] nxt_addr = '0;

  logic        cachereq_rdy, cacheresp_val, memreq_val, memreq_type, memresp_rdy;
  logic        cachereq_en, memresp_en, is_refill, tag_array_ren, data_array_ren;
  logic        read_data_reg_en, read_tag_reg_en, access_way;
  logic [1:0]  tag_array_wen, data_array_wen, read_byte_sel;
  logic [15:0] data_array_wben0, data_array_wben1;
  logic [9:0]  req_count, miss_count;

  integer seed = 45086;
  int errors = 0;
  int cycles = 0;
  int wr_total = 0;
  int rd_total = 0;
  int base_wr = 0;
  int base_rd = 0;
  int exp_wr = 0;
  int exp_rd = 0;
  logic [1:0]  exp_wen = '0;
  logic [31:0] exp_fill_ben = '0;
  logic [31:0] exp_word_ben = '0;
  logic [1:0]  exp_type = '0;
  logic [1:0]  exp_sel = '0;
  logic        exp_way = 1'b0;
  int model_reqs = 0;
  int model_misses = 0;

  // reference line state, lru holds the most recently used way
  logic [1:0]  mv [8];
  logic [1:0]  md [8];
  logic        mlru [8];
  logic [24:0] mtag [8][2];

  logic [24:0] tag_mem [2][8];
  int rdy_wait = 0;
  int resp_wait = 0;
  logic last_memreq_wr = 1'b0;
  logic data_read_seen = 1'b0;

  cache_ctrl_top dut (.*);

  always #5 clk = ~clk;

  // --------------------------------------------------------------------------
  // datapath model: request register and tag arrays
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < 8; s++) begin
        tag_mem[0][s] <= '0;
        tag_mem[1][s] <= '0;
      end
    end else begin
      if (cachereq_en) begin
        req_type <= nxt_type;
        req_addr <= nxt_addr;
      end
      if (tag_array_wen[0]) tag_mem[0][req_addr[6:4]] <= req_addr[31:7];
      if (tag_array_wen[1]) tag_mem[1][req_addr[6:4]] <= req_addr[31:7];
    end
  end

  always_comb begin
    tag_match[0] = (tag_mem[0][req_addr[6:4]] == req_addr[31:7]);
    tag_match[1] = (tag_mem[1][req_addr[6:4]] == req_addr[31:7]);
  end

  // data array reads of the request itself, victim reads left out
  always @(posedge clk) begin
    if (cachereq_en) begin
      data_read_seen <= 1'b0;
    end else if (data_array_ren && read_data_reg_en && !memreq_val) begin
      data_read_seen <= 1'b1;
    end
  end

  // memory with random ready and response delays
  always @(posedge clk) begin
    if (!reset) begin
      if (memreq_val && memreq_rdy) begin
        memreq_rdy <= 1'b0;
        last_memreq_wr <= memreq_type;
        if (memreq_type) wr_total <= wr_total + 1;
        else rd_total <= rd_total + 1;
      end else if (memreq_val) begin
        if (rdy_wait == 0) begin
          memreq_rdy <= 1'b1;
          rdy_wait <= $random(seed) & 3;
        end else begin
          rdy_wait <= rdy_wait - 1;
        end
      end
      if (memresp_val && memresp_rdy) begin
        memresp_val <= 1'b0;
      end else if (memresp_rdy && !memresp_val) begin
        if (resp_wait == 0) begin
          memresp_val <= 1'b1;
          resp_wait <= $random(seed) & 3;
        end else begin
          resp_wait <= resp_wait - 1;
        end
      end
      cacheresp_rdy <= (($random(seed) & 3) != 0);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: no progress after %0d cycles, errors %0d", cycles, errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic value_error(input string name, input longint got, input longint want);
    $display("CHECK FAILED t=%0t %s got %0h expected %0h", $time, name, got, want);
    errors++;
  endtask

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  assert property (@(posedge clk) $fell(reset) |-> cachereq_rdy)
    else value_error("cachereq_rdy", $sampled(cachereq_rdy), 1);
  assert property (@(posedge clk) $fell(reset) |->
    {cacheresp_val, memreq_val, memresp_rdy, tag_array_wen, data_array_wen} == '0)
    else value_error("handshake outputs and enables",
      $sampled({cacheresp_val, memreq_val, memresp_rdy, tag_array_wen, data_array_wen}), 0);
  assert property (@(posedge clk) $fell(reset) |-> {req_count, miss_count} == '0)
    else value_error("req_count, miss_count", $sampled({req_count, miss_count}), 0);

  // a read request comes after the write-back of a dirty victim
  assert property (@(posedge clk) disable iff (reset)
    (memreq_val && memreq_rdy && !memreq_type) |-> (wr_total - base_wr == exp_wr))
    else value_error("write-backs before memreq_read", $sampled(wr_total - base_wr),
                     $sampled(exp_wr));
  assert property (@(posedge clk) disable iff (reset)
    (cacheresp_val && cacheresp_rdy) |-> (wr_total - base_wr == exp_wr))
    else value_error("memreq_write count", $sampled(wr_total - base_wr), $sampled(exp_wr));
  assert property (@(posedge clk) disable iff (reset)
    (cacheresp_val && cacheresp_rdy) |-> (rd_total - base_rd == exp_rd))
    else value_error("memreq_read count", $sampled(rd_total - base_rd), $sampled(exp_rd));

  assert property (@(posedge clk) disable iff (reset)
    (|data_array_wen) |-> (data_array_wen == exp_wen))
    else value_error("data_array_wen", $sampled(data_array_wen), $sampled(exp_wen));
  assert property (@(posedge clk) disable iff (reset)
    (|tag_array_wen) |-> (tag_array_wen == exp_wen))
    else value_error("tag_array_wen", $sampled(tag_array_wen), $sampled(exp_wen));
  assert property (@(posedge clk) disable iff (reset)
    (|data_array_wen && is_refill) |->
      ({data_array_wben1, data_array_wben0} == exp_fill_ben))
    else value_error("refill data_array_wben1, data_array_wben0",
                     $sampled({data_array_wben1, data_array_wben0}), $sampled(exp_fill_ben));
  assert property (@(posedge clk) disable iff (reset)
    (|data_array_wen && !is_refill) |->
      ({data_array_wben1, data_array_wben0} == exp_word_ben))
    else value_error("word data_array_wben1, data_array_wben0",
                     $sampled({data_array_wben1, data_array_wben0}), $sampled(exp_word_ben));

  // datapath enables
  assert property (@(posedge clk) disable iff (reset)
    cachereq_en |=> tag_array_ren)
    else value_error("tag_array_ren in tag check", $sampled(tag_array_ren), 1);
  assert property (@(posedge clk) disable iff (reset)
    (memreq_val && memreq_type) |->
      ({tag_array_ren, read_tag_reg_en, data_array_ren, read_data_reg_en} == 4'hf))
    else value_error("victim read enables",
      $sampled({tag_array_ren, read_tag_reg_en, data_array_ren, read_data_reg_en}), 4'hf);
  assert property (@(posedge clk) disable iff (reset)
    memresp_en == (memresp_val && memresp_rdy && !last_memreq_wr))
    else value_error("memresp_en", $sampled(memresp_en),
                     $sampled(memresp_val && memresp_rdy && !last_memreq_wr));
  assert property (@(posedge clk) disable iff (reset)
    (cacheresp_val && cacheresp_rdy) |-> (data_read_seen == (exp_type == 2'd0)))
    else value_error("data array read for request", $sampled(data_read_seen),
                     $sampled(exp_type == 2'd0));
  assert property (@(posedge clk) disable iff (reset)
    cacheresp_val |-> (access_way == exp_way))
    else value_error("access_way", $sampled(access_way), $sampled(exp_way));
  assert property (@(posedge clk) disable iff (reset)
    cacheresp_val |-> (read_byte_sel == exp_sel))
    else value_error("read_byte_sel", $sampled(read_byte_sel), $sampled(exp_sel));

  // --------------------------------------------------------------------------
  // reference model, updated on the accepting edge
  // --------------------------------------------------------------------------
  task automatic predict_request(input logic [1:0] t, input logic [31:0] a);
    logic [2:0]  s;
    logic [24:0] tg;
    logic        w;
    logic        h;
    logic [15:0] ben;
    s = a[6:4];
    tg = a[31:7];
    h = 1'b0;
    w = ~mlru[s];
    if (t != 2'd2) begin
      for (int i = 0; i < 2; i++) begin
        if (mv[s][i] && mtag[s][i] == tg) begin
          h = 1'b1;
          w = i[0];
        end
      end
    end
    // byte b of the line belongs to word b[3:2]
    for (int b = 0; b < 16; b++) begin
      ben[b] = (b[3:2] == a[3:2]);
    end
    exp_wr <= (t != 2'd2 && !h && mv[s][w] && md[s][w]) ? 1 : 0;
    exp_rd <= (t != 2'd2 && !h) ? 1 : 0;
    if (t != 2'd2 && !h) model_misses++;
    exp_wen <= w ? 2'b10 : 2'b01;
    exp_fill_ben <= w ? {16'hffff, 16'h0000} : {16'h0000, 16'hffff};
    exp_word_ben <= w ? {ben, 16'h0000} : {16'h0000, ben};
    exp_type <= t;
    exp_sel <= a[3:2];
    exp_way <= w;
    if (!h) begin
      mv[s][w] = 1'b1;
      md[s][w] = 1'b0;
      mtag[s][w] = tg;
    end
    if (t == 2'd1) md[s][w] = 1'b1;
    mlru[s] = w;
    model_reqs++;
    base_wr <= wr_total;
    base_rd <= rd_total;
  endtask

  task automatic run_request(input logic [1:0] t, input logic [31:0] a);
    nxt_type <= t;
    nxt_addr <= a;
    cachereq_val <= 1'b1;
    do @(posedge clk); while (!cachereq_rdy);
    predict_request(t, a);
    cachereq_val <= 1'b0;
    do @(posedge clk); while (!(cacheresp_val && cacheresp_rdy));
  endtask

  function automatic logic [31:0] make_addr(input int tg, input int s, input int word);
    return {tg[24:0], s[2:0], word[1:0], 2'b00};
  endfunction

  initial begin
    int r;
    int init_tags;
    init_tags = 100;
    for (int s = 0; s < 8; s++) begin
      mv[s] = '0;
      md[s] = '0;
      mlru[s] = 1'b0;
      mtag[s][0] = '0;
      mtag[s][1] = '0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // set 5: clean misses, hits, dirty eviction, write-init
    run_request(2'd0, make_addr(1, 5, 0));
    run_request(2'd0, make_addr(2, 5, 1));
    run_request(2'd0, make_addr(1, 5, 2));
    run_request(2'd1, make_addr(1, 5, 3));
    run_request(2'd0, make_addr(3, 5, 0));
    run_request(2'd1, make_addr(3, 5, 2));
    run_request(2'd0, make_addr(1, 5, 1));
    run_request(2'd0, make_addr(4, 5, 3));
    run_request(2'd2, make_addr(init_tags, 5, 1));

    for (int i = 0; i < n_random; i++) begin
      r = $random(seed) & 7;
      if (r == 7) begin
        init_tags++;
        run_request(2'd2, make_addr(init_tags, $random(seed) & 3, $random(seed) & 3));
      end else begin
        run_request((r < 4) ? 2'd0 : 2'd1,
                    make_addr(($random(seed) & 1) + 1 + (r & 1), $random(seed) & 3,
                              $random(seed) & 3));
      end
    end
    repeat (2) @(posedge clk);

    assert (req_count == 10'(model_reqs))
      else value_error("req_count", req_count, 10'(model_reqs));
    assert (miss_count == 10'(model_misses))
      else value_error("miss_count", miss_count, 10'(model_misses));

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
